// ==== hdl/elevator_defs.svh ====
/*
 * Elevator floor-request controller
 * Project-wide sizes for the floor set and the request queue
 */

`ifndef ELEVATOR_DEFS_SVH
`define ELEVATOR_DEFS_SVH

////////////////////
// Floors
////////////////////

// Floors served by the car, floor 1 encoded as 0
`define NUM_FLOORS 11
`define FLOOR_W 4

////////////////////
// Request queue
////////////////////

// Depth must stay a power of two so the pointers wrap on their own
`define QUEUE_DEPTH 16
`define QUEUE_PTR_W 4

`endif

// ==== hdl/elevator_pkg.sv ====
/*
 * Elevator package
 * Vector types for floors, button masks and queue pointers,
 * plus the dispatcher state encoding
 */

`default_nettype none

`include "elevator_defs.svh"

package elevator_pkg;

    // Floor number, floor 1 is 0
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor, used for buttons and lamps
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    // Request queue read or write pointer
    typedef logic [`QUEUE_PTR_W-1:0] queue_ptr_t;

    // Dispatcher states
    typedef enum logic [1:0] {
        st_idle,
        st_dispatch,
        st_travel,
        st_arrive
    } dispatch_state_t;

endpackage

`default_nettype wire

// ==== hdl/request_latch.sv ====
/*
 * Button request latch
 * Latches one set of floor buttons into lamps and offers the lowest
 * lit floor that has not been written to the queue yet
 */

`timescale 1ns/1ps
`default_nettype none

`include "elevator_defs.svh"

module request_latch (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire elevator_pkg::floor_mask_t buttons,
    input  wire elevator_pkg::floor_t current_floor,
    input  wire                       accept_enable,
    input  wire                       arrival,
    input  wire                       grant,
    output elevator_pkg::floor_mask_t lights,
    output logic                      request,
    output elevator_pkg::floor_t      request_floor
);
    import elevator_pkg::*;

    floor_mask_t queued;
    floor_mask_t pending;
    floor_mask_t set_mask;
    floor_mask_t grant_mask;
    floor_mask_t clear_mask;

    ////////////////////
    // Per-floor updates
    ////////////////////

    always_comb begin
        set_mask   = '0;
        grant_mask = '0;
        clear_mask = '0;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            // New press, ignored at the floor the car is standing on
            if (buttons[i] && accept_enable && !lights[i] &&
                current_floor != floor_t'(i)) begin
                set_mask[i] = 1'b1;
            end
            if (grant && request_floor == floor_t'(i)) begin
                grant_mask[i] = 1'b1;
            end
            // Car has stopped here, service done
            if (arrival && current_floor == floor_t'(i)) begin
                clear_mask[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
            queued <= '0;
        end else begin
            lights <= (lights | set_mask) & ~clear_mask;
            queued <= (queued | grant_mask) & ~clear_mask;
        end
    end

    ////////////////////
    // Request offer
    ////////////////////

    // Lit but not yet in the queue
    assign pending = lights & ~queued;
    assign request = |pending;

    // Lowest floor first, scan downward so the last hit wins
    always_comb begin
        request_floor = '0;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                request_floor = floor_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/request_arbiter.sv ====
/*
 * Request arbiter
 * Round-robin choice between panel and hall requests for the
 * single queue write port, stalls while the queue is full
 */

`timescale 1ns/1ps
`default_nettype none

module request_arbiter (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       panel_request,
    input  wire elevator_pkg::floor_t panel_floor,
    input  wire                       hall_request,
    input  wire elevator_pkg::floor_t hall_floor,
    input  wire                       queue_full,
    output logic                      panel_grant,
    output logic                      hall_grant,
    output logic                      write,
    output elevator_pkg::floor_t      write_floor
);

    // Set when the hall side won the last grant
    logic last_was_hall;
    logic pick_hall;

    // Hall wins when alone, or when panel won last time
    assign pick_hall = hall_request && (!panel_request || !last_was_hall);

    // Nothing granted while full, the latches just keep requesting
    assign hall_grant  = pick_hall && !queue_full;
    assign panel_grant = panel_request && !pick_hall && !queue_full;

    assign write       = panel_grant || hall_grant;
    assign write_floor = pick_hall ? hall_floor : panel_floor;

    // Reset as if hall had won, so panel goes first
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            last_was_hall <= 1'b1;
        end else if (write) begin
            last_was_hall <= hall_grant;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/request_queue.sv ====
/*
 * Request queue
 * First-in-first-out store of requested floor numbers with a
 * fall-through head, read straight from the read pointer
 */

`timescale 1ns/1ps
`default_nettype none

`include "elevator_defs.svh"

module request_queue (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       write,
    input  wire elevator_pkg::floor_t write_floor,
    input  wire                       pop,
    output elevator_pkg::floor_t      head_floor,
    output logic                      empty,
    output logic                      full
);
    import elevator_pkg::*;

    floor_t     mem [`QUEUE_DEPTH];
    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;

    // One bit wider than a pointer to tell full from empty
    logic [`QUEUE_PTR_W:0] count;

    logic do_write;
    logic do_pop;

    assign empty = (count == 0);
    assign full  = (count == `QUEUE_DEPTH);

    // Guard against overflow and underflow
    assign do_write = write && !full;
    assign do_pop   = pop && !empty;

    assign head_floor = mem[rd_ptr];

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= write_floor;
        end
    end

    ////////////////////
    // Pointers and fill
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dispatch_control.sv ====
/*
 * Dispatch control
 * Pops floor targets in arrival order, drives the car controller,
 * detects arrival and grants door permission
 */

`timescale 1ns/1ps
`default_nettype none

module dispatch_control (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       power_switch,
    input  wire                       emergency_btn,
    input  wire                       door_open_btn,
    input  wire                       door_close_btn,
    input  wire elevator_pkg::floor_t current_floor,
    input  wire                       elevator_moving,
    input  wire elevator_pkg::floor_t head_floor,
    input  wire                       queue_empty,
    output logic                      pop,
    output logic                      accept_enable,
    output logic                      arrival,
    output elevator_pkg::floor_t      elevator_floor_selector,
    output logic                      direction_selector,
    output logic                      activate_elevator,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);
    import elevator_pkg::*;

    dispatch_state_t state;
    dispatch_state_t next_state;
    logic            car_stopped;

    assign accept_enable = power_switch && !emergency_btn;
    assign car_stopped   = !elevator_moving;

    ////////////////////
    // State machine
    ////////////////////

    // Take the next target only with the car standing still
    assign pop = (state == st_idle) && !queue_empty && accept_enable && car_stopped;

    assign activate_elevator = (state == st_dispatch);
    assign arrival           = (state == st_arrive);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                // Duplicate request for this floor, no trip needed
                if (pop) begin
                    next_state = (head_floor == current_floor) ? st_arrive : st_dispatch;
                end
            end
            st_dispatch: begin
                // Hold activate until the car reports motion
                if (elevator_moving) begin
                    next_state = st_travel;
                end
            end
            st_travel: begin
                if (car_stopped && current_floor == elevator_floor_selector) begin
                    next_state = st_arrive;
                end
            end
            st_arrive: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Target and direction captured at the pop edge
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state                   <= st_idle;
            elevator_floor_selector <= '0;
            direction_selector      <= 1'b0;
        end else begin
            state <= next_state;
            if (pop) begin
                elevator_floor_selector <= head_floor;
                direction_selector      <= (head_floor > current_floor);
            end
        end
    end

    ////////////////////
    // Door permission
    ////////////////////

    // Buttons pass through only when stopped and powered
    assign door_open_allowed  = door_open_btn && car_stopped && power_switch;
    assign door_close_allowed = door_close_btn && car_stopped && power_switch;

endmodule

`default_nettype wire

// ==== hdl/floor_logic_top.sv ====
/*
 * Elevator floor logic top level
 * Panel and hall request latches share one queue through an
 * arbiter, a dispatcher serves the queue toward the car controller
 */

`timescale 1ns/1ps
`default_nettype none

module floor_logic_top (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire elevator_pkg::floor_mask_t call_buttons,
    input  wire                            door_open_btn,
    input  wire                            door_close_btn,
    input  wire                            emergency_btn,
    input  wire                            power_switch,
    input  wire elevator_pkg::floor_t      current_floor,
    input  wire                            elevator_moving,
    output elevator_pkg::floor_t           elevator_floor_selector,
    output logic                           direction_selector,
    output logic                           activate_elevator,
    output logic                           door_open_allowed,
    output logic                           door_close_allowed,
    output elevator_pkg::floor_mask_t      panel_button_lights,
    output elevator_pkg::floor_mask_t      call_button_lights
);
    import elevator_pkg::*;

    // Request path
    logic   panel_request;
    floor_t panel_floor;
    logic   panel_grant;
    logic   hall_request;
    floor_t hall_floor;
    logic   hall_grant;
    logic   queue_write;
    floor_t queue_write_floor;

    // Dispatch path
    floor_t head_floor;
    logic   queue_empty;
    logic   queue_full;
    logic   queue_pop;
    logic   accept_enable;
    logic   arrival;

    ////////////////////
    // Request latches
    ////////////////////

    request_latch i_panel_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (panel_buttons),
        .current_floor (current_floor),
        .accept_enable (accept_enable),
        .arrival       (arrival),
        .grant         (panel_grant),
        .lights        (panel_button_lights),
        .request       (panel_request),
        .request_floor (panel_floor)
    );

    request_latch i_hall_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (call_buttons),
        .current_floor (current_floor),
        .accept_enable (accept_enable),
        .arrival       (arrival),
        .grant         (hall_grant),
        .lights        (call_button_lights),
        .request       (hall_request),
        .request_floor (hall_floor)
    );

    ////////////////////
    // Queue and dispatch
    ////////////////////

    request_arbiter i_request_arbiter (
        .clock         (clock),
        .reset_n       (reset_n),
        .panel_request (panel_request),
        .panel_floor   (panel_floor),
        .hall_request  (hall_request),
        .hall_floor    (hall_floor),
        .queue_full    (queue_full),
        .panel_grant   (panel_grant),
        .hall_grant    (hall_grant),
        .write         (queue_write),
        .write_floor   (queue_write_floor)
    );

    request_queue i_request_queue (
        .clock       (clock),
        .reset_n     (reset_n),
        .write       (queue_write),
        .write_floor (queue_write_floor),
        .pop         (queue_pop),
        .head_floor  (head_floor),
        .empty       (queue_empty),
        .full        (queue_full)
    );

    dispatch_control i_dispatch_control (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .head_floor              (head_floor),
        .queue_empty             (queue_empty),
        .pop                     (queue_pop),
        .accept_enable           (accept_enable),
        .arrival                 (arrival),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

`default_nettype wire

// ==== verif/floor_logic_tb.sv ====
/*
 * Floor logic testbench
 * Directed tests of the floor-request controller, driven against a
 * behavioral car that travels one floor per random delay
 */

`timescale 1ns/1ps
`default_nettype none

`include "elevator_defs.svh"

module floor_logic_tb;
    import elevator_pkg::*;

    localparam int WAIT_LIMIT = 200;

    // DUT inputs
    logic        clock = 1'b0;
    logic        reset_n = 1'b0;
    floor_mask_t panel_buttons = '0;
    floor_mask_t call_buttons = '0;
    logic        door_open_btn = 1'b0;
    logic        door_close_btn = 1'b0;
    logic        emergency_btn = 1'b0;
    logic        power_switch = 1'b1;
    floor_t      current_floor = '0;
    logic        elevator_moving = 1'b0;

    // DUT outputs
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t panel_button_lights;
    floor_mask_t call_button_lights;

    // Car held in motion while set
    logic   hold_car = 1'b0;
    // Floors in expected grant order
    floor_t expected_q[$];
    // After reset the panel side goes first
    bit     last_hall = 1'b1;
    int     error_count = 0;
    int     timeout_count = 0;

    floor_logic_top i_floor_logic_top (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .panel_buttons           (panel_buttons),
        .call_buttons            (call_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed),
        .panel_button_lights     (panel_button_lights),
        .call_button_lights      (call_button_lights)
    );

    always #2 clock = ~clock;

    ////////////////////
    // Car model
    ////////////////////

    initial begin : car_model
        floor_t pos;
        floor_t target;
        int     delay;
        // Travel delays come from a fixed seed
        void'($urandom(32'h164cbefa));
        forever begin
            @(posedge clock);
            if (hold_car) begin
                elevator_moving <= 1'b1;
            end else if (activate_elevator) begin
                elevator_moving <= 1'b1;
                target = elevator_floor_selector;
                pos = current_floor;
                while (pos != target) begin
                    delay = 2 + int'($urandom % 4);
                    repeat (delay) @(posedge clock);
                    pos = (target > pos) ? pos + 4'd1 : pos - 4'd1;
                    current_floor <= pos;
                end
                elevator_moving <= 1'b0;
            end else begin
                elevator_moving <= 1'b0;
            end
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            error_count++;
            $display("Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        timeout_count++;
        $display("Timeout in %s: %s", name, what);
    endtask

    function automatic floor_mask_t floor_bit(input int f);
        return floor_mask_t'(1) << f;
    endfunction

    // One-cycle press, the next press or release follows on the next edge
    task automatic press(input floor_mask_t panel, input floor_mask_t call);
        @(posedge clock);
        panel_buttons <= panel;
        call_buttons  <= call;
    endtask

    task automatic release_buttons();
        @(posedge clock);
        panel_buttons <= '0;
        call_buttons  <= '0;
    endtask

    task automatic record_single(input bit from_hall, input floor_t f);
        expected_q.push_back(f);
        last_hall = from_hall;
    endtask

    // Both sides request together, the side that lost last time wins
    task automatic record_pair(input floor_t panel_f, input floor_t hall_f);
        if (last_hall) begin
            expected_q.push_back(panel_f);
            expected_q.push_back(hall_f);
        end else begin
            expected_q.push_back(hall_f);
            expected_q.push_back(panel_f);
        end
    endtask

    task automatic check_lights(input string name, input floor_mask_t panel,
                                input floor_mask_t call);
        check_value({name, " panel lights"}, int'(panel), int'(panel_button_lights));
        check_value({name, " call lights"}, int'(call), int'(call_button_lights));
    endtask

    task automatic wait_moving(input string name, input logic level);
        int waited;
        waited = 0;
        while (elevator_moving != level && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (elevator_moving != level) begin
            report_timeout(name, "car motion never changed");
        end
    endtask

    // One trip: activation checked, then the car followed to a stop
    task automatic serve_one(input string name, input floor_t target);
        int waited;
        waited = 0;
        while (!activate_elevator && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (!activate_elevator) begin
            report_timeout(name, "car was never activated");
        end else begin
            check_value({name, " selector"}, int'(target), int'(elevator_floor_selector));
            check_value({name, " direction"}, int'(target > current_floor),
                        int'(direction_selector));
            waited = 0;
            while ((activate_elevator || elevator_moving ||
                    current_floor != elevator_floor_selector) && waited < WAIT_LIMIT) begin
                @(posedge clock);
                waited++;
            end
            if (elevator_moving || current_floor != elevator_floor_selector) begin
                report_timeout(name, "car never stopped at its target");
            end
        end
    endtask

    task automatic serve_all(input string name);
        floor_t target;
        while (expected_q.size() > 0) begin
            target = expected_q.pop_front();
            serve_one(name, target);
        end
    endtask

    task automatic wait_lights_clear(input string name);
        int waited;
        waited = 0;
        while ((panel_button_lights != '0 || call_button_lights != '0) &&
               waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (panel_button_lights != '0 || call_button_lights != '0) begin
            report_timeout(name, "button lights never cleared");
        end
    endtask

    task automatic expect_no_activation(input string name, input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            check_value({name, " activate"}, 0, int'(activate_elevator));
        end
    endtask

    task automatic check_doors(input string name, input logic power, input logic open,
                               input logic close);
        @(posedge clock);
        power_switch   <= power;
        door_open_btn  <= open;
        door_close_btn <= close;
        @(posedge clock);
        check_value({name, " open"}, int'(open && power && !elevator_moving),
                    int'(door_open_allowed));
        check_value({name, " close"}, int'(close && power && !elevator_moving),
                    int'(door_close_allowed));
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_single_request();
        press(floor_bit(5), '0);
        release_buttons();
        @(posedge clock);
        check_lights("single", floor_bit(5), '0);
        record_single(1'b0, 4'd5);
        serve_all("single");
        wait_lights_clear("single");
    endtask

    task automatic test_ignored_presses();
        // Car stands at floor index 5 here
        press(floor_bit(5), floor_bit(5));
        release_buttons();
        @(posedge clock);
        check_lights("current floor", '0, '0);
        @(posedge clock);
        power_switch <= 1'b0;
        press(floor_bit(2), floor_bit(8));
        release_buttons();
        expect_no_activation("power off", 20);
        check_lights("power off", '0, '0);
        @(posedge clock);
        power_switch  <= 1'b1;
        emergency_btn <= 1'b1;
        press(floor_bit(2), floor_bit(8));
        release_buttons();
        expect_no_activation("emergency", 20);
        check_lights("emergency", '0, '0);
        @(posedge clock);
        emergency_btn <= 1'b0;
    endtask

    task automatic test_service_order();
        press(floor_bit(9), '0);
        press('0, floor_bit(1));
        press(floor_bit(3), '0);
        press('0, floor_bit(10));
        press(floor_bit(7), '0);
        release_buttons();
        record_single(1'b0, 4'd9);
        record_single(1'b1, 4'd1);
        record_single(1'b0, 4'd3);
        record_single(1'b1, 4'd10);
        record_single(1'b0, 4'd7);
        serve_all("order");
        wait_lights_clear("order");
    endtask

    task automatic test_simultaneous();
        press(floor_bit(2), floor_bit(4));
        release_buttons();
        record_pair(4'd2, 4'd4);
        serve_all("simultaneous");
        wait_lights_clear("simultaneous");
        press(floor_bit(6), floor_bit(6));
        release_buttons();
        record_pair(4'd6, 4'd6);
        // The second copy pops with the car already standing there
        void'(expected_q.pop_back());
        serve_all("same floor");
        wait_lights_clear("same floor");
        expect_no_activation("same floor", 20);
    endtask

    task automatic test_door_permission();
        check_doors("door stopped", 1'b1, 1'b0, 1'b0);
        check_doors("door stopped", 1'b1, 1'b1, 1'b0);
        check_doors("door stopped", 1'b1, 1'b0, 1'b1);
        check_doors("door stopped", 1'b1, 1'b1, 1'b1);
        check_doors("door power off", 1'b0, 1'b1, 1'b1);
        @(posedge clock);
        hold_car <= 1'b1;
        wait_moving("door moving", 1'b1);
        check_doors("door moving", 1'b1, 1'b1, 1'b1);
        @(posedge clock);
        hold_car <= 1'b0;
        wait_moving("door moving", 1'b0);
        check_doors("door stopped", 1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_back_pressure();
        floor_mask_t lit;
        lit = '0;
        @(posedge clock);
        hold_car <= 1'b1;
        wait_moving("back-pressure", 1'b1);
        // Every floor but the current one, panel first, then hall
        for (int f = 0; f < `NUM_FLOORS; f++) begin
            if (floor_t'(f) != current_floor) begin
                press(floor_bit(f), '0);
                record_single(1'b0, floor_t'(f));
                lit = lit | floor_bit(f);
            end
        end
        for (int f = 0; f < `NUM_FLOORS; f++) begin
            if (floor_t'(f) != current_floor) begin
                press('0, floor_bit(f));
                record_single(1'b1, floor_t'(f));
            end
        end
        release_buttons();
        repeat (4) @(posedge clock);
        check_lights("back-pressure", lit, lit);
        hold_car <= 1'b0;
        serve_all("back-pressure");
        wait_lights_clear("back-pressure");
    endtask

    initial begin
        repeat (8) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        check_value("reset activate", 0, int'(activate_elevator));
        check_value("reset direction", 0, int'(direction_selector));
        check_value("reset selector", 0, int'(elevator_floor_selector));
        check_lights("reset", '0, '0);

        test_single_request();
        test_ignored_presses();
        test_service_order();
        test_simultaneous();
        test_door_permission();
        test_back_pressure();

        $display("Checks done with %0d errors and %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/elevator_pkg.sv
hdl/request_latch.sv
hdl/request_arbiter.sv
hdl/request_queue.sv
hdl/dispatch_control.sv
hdl/floor_logic_top.sv
verif/floor_logic_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the floor logic testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module floor_logic_tb -f all.f -o floor_logic_sim \
    && ./obj_dir/floor_logic_sim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null \
    && echo "Simulation run OK" \
    || { echo "Simulation run FAILED"; exit 1; }
